// File: hw/aes_ks_defines.svh
/*
 * AES key schedule constants
 * Register size, last update round per key length and Rcon start bytes
 */

`ifndef AES_KS_DEFINES_SVH
`define AES_KS_DEFINES_SVH

// 32-bit words in the full key register
`define AES_KS_NUM_WORDS 8

// Last update round, counted from 1
`define AES_KS_LAST_RND_128 4'd10
`define AES_KS_LAST_RND_256 4'd13

// Rcon start bytes, forward always starts at x^0
`define AES_KS_RCON_FWD     8'h01
`define AES_KS_RCON_INV_128 8'h36
`define AES_KS_RCON_INV_256 8'h40

`endif

// File: hw/aes_ks_pkg.sv
/*
 * AES key schedule package
 * Direction and key length types, key and config containers,
 * GF(2^8) helpers and RotWord
 */

`default_nettype none

`include "aes_ks_defines.svh"

package aes_ks_pkg;

  // Expansion direction
  typedef enum logic {KS_FWD = 1'b0, KS_INV = 1'b1} ks_op_e;

  // Supported key lengths
  typedef enum logic {KS_AES_128 = 1'b0, KS_AES_256 = 1'b1} ks_key_len_e;

  typedef logic [31:0] ks_word_t;

  // Word 0 sits in the least significant bits
  typedef ks_word_t [`AES_KS_NUM_WORDS-1:0] ks_key_t;

  typedef struct packed {
    ks_op_e      op;
    ks_key_len_e key_len;
  } ks_cfg_t;

  typedef logic [3:0] ks_rnd_t;

  // Multiply by x, reduce with x^8 + x^4 + x^3 + x + 1
  function automatic logic [7:0] gf_mul2(logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  // Divide by x, an odd byte first takes the reduction polynomial back out
  function automatic logic [7:0] gf_div2(logic [7:0] b);
    return b[0] ? {1'b1, b[7:1] ^ 7'h0d} : {1'b0, b[7:1]};
  endfunction

  // RotWord, byte 1 moves into byte 0
  function automatic ks_word_t rot_word(ks_word_t w);
    return {w[7:0], w[31:8]};
  endfunction

endpackage

`default_nettype wire

// File: hw/aes_ks_sbox.sv
/*
 * AES forward S-box
 * Plain 256-entry lookup, byte 00 is the top entry of the table
 */

`timescale 1ns/1ns
`default_nettype none

module aes_ks_sbox (
  input  logic [7:0] data_i,
  output logic [7:0] data_o
);

  // One row per high nibble, low nibble runs left to right
  localparam logic [2047:0] sbox_lut = {
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };

  logic [7:0] idx;

  // Entry 0 is stored in the most significant byte
  assign idx    = 8'hff - data_i;
  assign data_o = sbox_lut[idx*8 +: 8];

endmodule

`default_nettype wire

// File: hw/aes_ks_ctrl.sv
/*
 * AES key schedule controller
 * Takes a start pulse, issues one load cycle, then steps until the last round
 */

`timescale 1ns/1ns
`default_nettype none

module aes_ks_ctrl (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                start_i,
  input  aes_ks_pkg::ks_cfg_t cfg_i,
  input  logic                last_i,
  output aes_ks_pkg::ks_cfg_t cfg_o,
  output logic                load_o,
  output logic                step_o,
  output logic                key_valid_o,
  output logic                done_o,
  output logic                busy_o
);

  typedef enum logic [1:0] {ST_IDLE, ST_LOAD, ST_RUN} state_e;

  state_e              state_q, state_d;
  aes_ks_pkg::ks_cfg_t cfg_q;
  logic                valid_q, done_q;

  // Next state
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: if (start_i) state_d = ST_LOAD;
      ST_LOAD: state_d = ST_RUN;
      ST_RUN:  if (last_i) state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      cfg_q   <= '0;
      valid_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      // Config is frozen for the whole run
      if (state_q == ST_IDLE && start_i) cfg_q <= cfg_i;
      // Flags trail the update edge by one cycle
      valid_q <= step_o;
      done_q  <= step_o & last_i;
    end
  end

  assign cfg_o       = cfg_q;
  assign load_o      = (state_q == ST_LOAD);
  assign step_o      = (state_q == ST_RUN);
  assign busy_o      = (state_q != ST_IDLE);
  assign key_valid_o = valid_q;
  assign done_o      = done_q;

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  load_step_excl_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(load_o && step_o));

endmodule

`default_nettype wire

// File: hw/aes_ks_round_cnt.sv
/*
 * AES key schedule round counter
 * Current update round, round of the latest key and the last-round flag
 */

`timescale 1ns/1ns
`default_nettype none

`include "aes_ks_defines.svh"

module aes_ks_round_cnt (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    load_i,
  input  logic                    step_i,
  input  aes_ks_pkg::ks_key_len_e key_len_i,
  output aes_ks_pkg::ks_rnd_t     rnd_o,
  output aes_ks_pkg::ks_rnd_t     key_rnd_o,
  output logic                    last_o
);

  aes_ks_pkg::ks_rnd_t cnt_q, key_rnd_q, last_rnd;

  assign last_rnd = (key_len_i == aes_ks_pkg::KS_AES_256) ? `AES_KS_LAST_RND_256 :
                                                            `AES_KS_LAST_RND_128;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q     <= '0;
      key_rnd_q <= '0;
    end else if (load_i) begin
      cnt_q <= 4'd1;
    end else if (step_i) begin
      // Holds on the last round so the count stays in range
      if (!last_o) cnt_q <= cnt_q + 4'd1;
      // Round tag for the key written on this edge
      key_rnd_q <= cnt_q;
    end
  end

  assign rnd_o     = cnt_q;
  assign key_rnd_o = key_rnd_q;
  assign last_o    = (cnt_q == last_rnd);

  cnt_range_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cnt_q <= `AES_KS_LAST_RND_256);

endmodule

`default_nettype wire

// File: hw/aes_ks_rcon.sv
/*
 * AES key schedule round constant
 * Start byte per direction and key length, advanced by x or x^-1
 * on each round that consumes it
 */

`timescale 1ns/1ns
`default_nettype none

`include "aes_ks_defines.svh"

module aes_ks_rcon (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                load_i,
  input  logic                step_i,
  input  aes_ks_pkg::ks_cfg_t cfg_i,
  input  aes_ks_pkg::ks_rnd_t rnd_i,
  output logic [7:0]          rcon_o,
  output logic                use_rcon_o
);

  logic [7:0] rcon_q, rcon_d, rcon_init;
  logic       is_inv, is_256;

  assign is_inv = (cfg_i.op == aes_ks_pkg::KS_INV);
  assign is_256 = (cfg_i.key_len == aes_ks_pkg::KS_AES_256);

  assign rcon_init = !is_inv ? `AES_KS_RCON_FWD     :
                     is_256  ? `AES_KS_RCON_INV_256 : `AES_KS_RCON_INV_128;

  // AES-256 even rounds only substitute, no Rcon
  assign use_rcon_o = !(is_256 && !rnd_i[0]);

  always_comb begin
    if (load_i) begin
      rcon_d = rcon_init;
    end else if (is_inv) begin
      rcon_d = aes_ks_pkg::gf_div2(rcon_q);
    end else begin
      rcon_d = aes_ks_pkg::gf_mul2(rcon_q);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rcon_q <= '0;
    end else if (load_i || (step_i && use_rcon_o)) begin
      rcon_q <= rcon_d;
    end
  end

  assign rcon_o = rcon_q;

  // A zero Rcon would mean the load was skipped
  rcon_nonzero_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    step_i |-> rcon_q != 8'h00);

endmodule

`default_nettype wire

// File: hw/aes_ks_datapath.sv
/*
 * AES key schedule datapath
 * Full key register, irregular word (RotWord, SubWord, Rcon) and
 * the regular XOR mixing for AES-128/256 in both directions
 */

`timescale 1ns/1ns
`default_nettype none

module aes_ks_datapath (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                load_i,
  input  logic                step_i,
  input  aes_ks_pkg::ks_cfg_t cfg_i,
  input  aes_ks_pkg::ks_rnd_t rnd_i,
  input  logic [7:0]          rcon_i,
  input  logic                use_rcon_i,
  input  aes_ks_pkg::ks_key_t key_i,
  output aes_ks_pkg::ks_key_t key_o
);

  aes_ks_pkg::ks_key_t  key_q, key_d;
  aes_ks_pkg::ks_word_t rot_in, sub_in, sub_out, irregular;
  logic                 is_inv, is_256, use_rot;

  assign is_inv = (cfg_i.op == aes_ks_pkg::KS_INV);
  assign is_256 = (cfg_i.key_len == aes_ks_pkg::KS_AES_256);

  ////////////////////////////////////////////////////////////
  // Irregular word
  ////////////////////////////////////////////////////////////

  // Inverse AES-128 rebuilds the previous word 3 from words 3 and 2
  assign rot_in = is_256 ? (is_inv ? key_q[3] : key_q[7]) :
                           (is_inv ? key_q[3] ^ key_q[2] : key_q[3]);

  // AES-256 even rounds skip RotWord
  assign use_rot = !(is_256 && !rnd_i[0]);
  assign sub_in  = use_rot ? aes_ks_pkg::rot_word(rot_in) : rot_in;

  for (genvar i = 0; i < 4; i++) begin : gen_sbox
    aes_ks_sbox u_sbox (
      .data_i (sub_in[8*i +: 8]),
      .data_o (sub_out[8*i +: 8])
    );
  end

  // Rcon goes into byte 0 only
  assign irregular = {sub_out[31:8], sub_out[7:0] ^ (use_rcon_i ? rcon_i : 8'h00)};

  ////////////////////////////////////////////////////////////
  // Regular mixing
  ////////////////////////////////////////////////////////////

  always_comb begin
    key_d = key_q;
    if (!is_256) begin
      // Words 7..4 unused, they just hold
      key_d[0] = irregular ^ key_q[0];
      for (int i = 1; i < 4; i++) begin
        key_d[i] = is_inv ? (key_q[i-1] ^ key_q[i]) : (key_d[i-1] ^ key_q[i]);
      end
    end else if (!is_inv) begin
      // Old upper half moves down, new upper half is chained
      key_d[3:0] = key_q[7:4];
      key_d[4]   = irregular ^ key_q[0];
      for (int i = 1; i < 4; i++) begin
        key_d[i+4] = key_d[i+3] ^ key_q[i];
      end
    end else begin
      // Old lower half moves up, new lower half from neighbors
      key_d[7:4] = key_q[3:0];
      key_d[0]   = irregular ^ key_q[4];
      for (int i = 0; i < 3; i++) begin
        key_d[i+1] = key_q[4+i] ^ key_q[5+i];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q <= '0;
    end else if (load_i) begin
      key_q <= key_i;
    end else if (step_i) begin
      key_q <= key_d;
    end
  end

  assign key_o = key_q;

endmodule

`default_nettype wire

// File: hw/aes_ks_top.sv
/*
 * AES key schedule engine, top level
 * Controller, round counter, Rcon unit and key datapath
 */

`timescale 1ns/1ns
`default_nettype none

module aes_ks_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                start_i,
  input  aes_ks_pkg::ks_cfg_t cfg_i,
  input  aes_ks_pkg::ks_key_t key_i,
  output aes_ks_pkg::ks_key_t key_o,
  output aes_ks_pkg::ks_rnd_t rnd_o,
  output logic                key_valid_o,
  output logic                done_o,
  output logic                busy_o
);

  aes_ks_pkg::ks_cfg_t cfg;
  aes_ks_pkg::ks_rnd_t rnd;
  logic                load, step, last;
  logic [7:0]          rcon;
  logic                use_rcon;

  // Sequencing, key_i must still be valid in the load cycle
  aes_ks_ctrl i_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (start_i),
    .cfg_i       (cfg_i),
    .last_i      (last),
    .cfg_o       (cfg),
    .load_o      (load),
    .step_o      (step),
    .key_valid_o (key_valid_o),
    .done_o      (done_o),
    .busy_o      (busy_o)
  );

  aes_ks_round_cnt i_round_cnt (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .load_i    (load),
    .step_i    (step),
    .key_len_i (cfg.key_len),
    .rnd_o     (rnd),
    .key_rnd_o (rnd_o),
    .last_o    (last)
  );

  aes_ks_rcon i_rcon (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .load_i     (load),
    .step_i     (step),
    .cfg_i      (cfg),
    .rnd_i      (rnd),
    .rcon_o     (rcon),
    .use_rcon_o (use_rcon)
  );

  aes_ks_datapath i_datapath (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .load_i     (load),
    .step_i     (step),
    .cfg_i      (cfg),
    .rnd_i      (rnd),
    .rcon_i     (rcon),
    .use_rcon_i (use_rcon),
    .key_i      (key_i),
    .key_o      (key_o)
  );

endmodule

`default_nettype wire

// File: tests/aes_ks_tb.sv
/*
 * AES key schedule engine testbench
 * FIPS-197 vectors, round timing, inverse round trips and start while busy
 */

`timescale 1ns/1ns
`default_nettype none

module aes_ks_tb;

  localparam int CLK_PERIOD      = 100;
  localparam int NUM_TESTS       = 20;
  localparam int CYCLES_PER_TEST = 20;
  // Longest run is load plus 13 updates plus the done cycle
  localparam int RUN_LIMIT       = 20;

  logic                clk_i, rst_ni, start_i;
  aes_ks_pkg::ks_cfg_t cfg_i;
  aes_ks_pkg::ks_key_t key_i, key_o;
  aes_ks_pkg::ks_rnd_t rnd_o;
  logic                key_valid_o, done_o, busy_o;

  int err_cnt, tests_run, tests_failed, test_err_base;

  aes_ks_top i_dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (start_i),
    .cfg_i       (cfg_i),
    .key_i       (key_i),
    .key_o       (key_o),
    .rnd_o       (rnd_o),
    .key_valid_o (key_valid_o),
    .done_o      (done_o),
    .busy_o      (busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Watchdog sized from the test budget
  initial begin
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
    $display("Watchdog expired before all tests finished");
    $display("TEST FAIL");
    $finish;
  end

  // A key flag comes only inside a run or together with done_o in the last cycle
  key_flags_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (key_valid_o || done_o) |-> key_valid_o && (busy_o == !done_o))
    else begin
      $display("key_valid_o, done_o and busy_o out of step at %0t", $time);
      err_cnt++;
    end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // FIPS words list the first byte leftmost and the register keeps it in bits 7:0
  function automatic aes_ks_pkg::ks_word_t byte_swap(input logic [31:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  // Eight FIPS words with w0 leftmost go into register words 0..7
  function automatic aes_ks_pkg::ks_key_t from_fips(input logic [255:0] f);
    aes_ks_pkg::ks_key_t k;
    for (int i = 0; i < 8; i++) begin
      k[i] = byte_swap(f[255-32*i -: 32]);
    end
    return k;
  endfunction

  function automatic aes_ks_pkg::ks_key_t random_key();
    aes_ks_pkg::ks_key_t k;
    for (int i = 0; i < 8; i++) begin
      k[i] = $urandom;
    end
    return k;
  endfunction

  function automatic aes_ks_pkg::ks_cfg_t make_cfg(input aes_ks_pkg::ks_op_e op,
                                                    input aes_ks_pkg::ks_key_len_e len);
    aes_ks_pkg::ks_cfg_t c;
    c.op      = op;
    c.key_len = len;
    return c;
  endfunction

  task automatic check_value(input string name, input logic [255:0] got,
                             input logic [255:0] exp);
    value_a: assert (got === exp) else begin
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (err_cnt == test_err_base) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name,
               err_cnt - test_err_base);
    end
    test_err_base = err_cnt;
  endtask

  ////////////////////////////////////////////////////////////
  // One run of the engine with round timing checks
  ////////////////////////////////////////////////////////////

  // Called on a falling edge and returns on the falling edge after done_o
  task automatic run_ks(input aes_ks_pkg::ks_cfg_t cfg, input aes_ks_pkg::ks_key_t key,
                        input bit poke_busy, output aes_ks_pkg::ks_key_t result);
    int cycles;
    int pulses;
    int exp_pulses;
    bit seen_done;
    exp_pulses = (cfg.key_len == aes_ks_pkg::KS_AES_256) ? 13 : 10;
    cycles     = 0;
    pulses     = 0;
    seen_done  = 1'b0;
    result     = '0;
    start_i    = 1'b1;
    cfg_i      = cfg;
    key_i      = key;
    @(negedge clk_i);
    start_i = 1'b0;
    while (!seen_done && cycles < RUN_LIMIT) begin
      // Busy holds from the load cycle until the done cycle
      check_value("busy_o", busy_o, cycles <= exp_pulses);
      if (key_valid_o) begin
        pulses++;
        check_value("rnd_o", rnd_o, pulses);
      end else if (pulses > 0) begin
        $display("key_valid_o dropped after %0d pulses before the run ended", pulses);
        err_cnt++;
      end
      if (done_o) begin
        check_value("key_valid_o", key_valid_o, 1'b1);
        seen_done = 1'b1;
        result    = key_o;
      end
      // Extra start with another config and key that must be ignored
      start_i = poke_busy && cycles == 3;
      if (start_i) begin
        cfg_i = aes_ks_pkg::ks_cfg_t'(~cfg);
        key_i = random_key();
      end
      @(negedge clk_i);
      cycles++;
    end
    start_i = 1'b0;
    if (!seen_done) begin
      $display("done_o never came within %0d cycles of start", RUN_LIMIT);
      err_cnt++;
    end
    check_value("key_valid_o pulse count", pulses, exp_pulses);
  endtask

  // Forward from a random key and back again before comparing the original words
  task automatic round_trip(input aes_ks_pkg::ks_key_len_e len);
    aes_ks_pkg::ks_key_t orig, fwd, back;
    orig = random_key();
    run_ks(make_cfg(aes_ks_pkg::KS_FWD, len), orig, 1'b0, fwd);
    run_ks(make_cfg(aes_ks_pkg::KS_INV, len), fwd, 1'b0, back);
    if (len == aes_ks_pkg::KS_AES_256) begin
      check_value("key_o", back, orig);
    end else begin
      check_value("key_o[3:0]", back[3:0], orig[3:0]);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    aes_ks_pkg::ks_key_t key128, key256, exp128, exp256, res;
    err_cnt       = 0;
    tests_run     = 0;
    tests_failed  = 0;
    test_err_base = 0;
    void'($urandom(32'h16fe));
    rst_ni  = 1'b0;
    start_i = 1'b0;
    cfg_i   = '0;
    key_i   = '0;
    // FIPS-197 A.1 and A.3 cipher keys with their round 10 and round 14 keys
    key128 = from_fips({128'h2b7e151628aed2a6abf7158809cf4f3c, 128'h0});
    exp128 = from_fips({128'hd014f9a8c9ee2589e13f0cc8b6630ca6, 128'h0});
    key256 = from_fips({128'h603deb1015ca71be2b73aef0857d7781,
                        128'h1f352c073b6108d72d9810a30914dff4});
    exp256 = from_fips({128'h0, 128'hfe4890d1e6188d0b046df344706c631e});

    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_value("key_valid_o", key_valid_o, 1'b0);
    check_value("done_o", done_o, 1'b0);
    check_value("busy_o", busy_o, 1'b0);
    check_value("key_o", key_o, '0);
    end_test("reset");

    run_ks(make_cfg(aes_ks_pkg::KS_FWD, aes_ks_pkg::KS_AES_128), key128, 1'b0, res);
    check_value("key_o[3:0]", res[3:0], exp128[3:0]);
    end_test("aes128 forward vector");

    run_ks(make_cfg(aes_ks_pkg::KS_FWD, aes_ks_pkg::KS_AES_256), key256, 1'b0, res);
    check_value("key_o[7:4]", res[7:4], exp256[7:4]);
    end_test("aes256 forward vector");

    for (int i = 0; i < 3; i++) begin
      round_trip(aes_ks_pkg::KS_AES_128);
      end_test("aes128 round trip");
    end
    for (int i = 0; i < 3; i++) begin
      round_trip(aes_ks_pkg::KS_AES_256);
      end_test("aes256 round trip");
    end

    run_ks(make_cfg(aes_ks_pkg::KS_FWD, aes_ks_pkg::KS_AES_128), key128, 1'b1, res);
    check_value("key_o[3:0]", res[3:0], exp128[3:0]);
    end_test("aes128 start while busy");

    run_ks(make_cfg(aes_ks_pkg::KS_FWD, aes_ks_pkg::KS_AES_256), key256, 1'b1, res);
    check_value("key_o[7:4]", res[7:4], exp256[7:4]);
    end_test("aes256 start while busy");

    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed,
             err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+hw
hw/aes_ks_pkg.sv
hw/aes_ks_sbox.sv
hw/aes_ks_ctrl.sv
hw/aes_ks_round_cnt.sv
hw/aes_ks_rcon.sv
hw/aes_ks_datapath.sv
hw/aes_ks_top.sv
tests/aes_ks_tb.sv

// File: Bender.yml
package:
  name: aes_ks

sources:
  - include_dirs:
      - hw
    files:
      - hw/aes_ks_pkg.sv
      - hw/aes_ks_sbox.sv
      - hw/aes_ks_ctrl.sv
      - hw/aes_ks_round_cnt.sv
      - hw/aes_ks_rcon.sv
      - hw/aes_ks_datapath.sv
      - hw/aes_ks_top.sv
  - target: test
    files:
      - tests/aes_ks_tb.sv
